// File: dv/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset lets go shortly after an edge like every other input
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int          MEM_HALVES = 1024;   // 2 KiB of program
    localparam int          NUM_ROWS   = 8;
    localparam logic [31:0] SEED       = 32'h3a7e057c;

    typedef struct packed {
        fetch_pkg::addr_t redirect_pc;
        logic [7:0]       stall_level;   // Stall when a random byte falls below this
        logic [15:0]      inst_count;    // Instructions taken before the next flush
    } scenario_t;

    logic                clk;
    logic                rstn;
    logic                flush;
    fetch_pkg::addr_t    redirect_pc;
    logic                stall;
    logic                mem_req;
    fetch_pkg::addr_t    mem_addr;
    fetch_pkg::mem_rsp_t mem_rsp;
    logic                mem_rsp_ready;
    fetch_pkg::dec_out_t dec;

    scenario_t   rows [NUM_ROWS];
    logic [31:0] rng_state;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) u_clk (.clk_o(clk), .rstn_o(rstn));

    tb_imem_model #(.HALVES(MEM_HALVES)) u_imem (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .req_i       (mem_req),
        .addr_i      (mem_addr),
        .rsp_ready_i (mem_rsp_ready),
        .rsp_o       (mem_rsp)
    );

    fetch_top UUT (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .flush_i         (flush),
        .redirect_pc_i   (redirect_pc),
        .stall_i         (stall),
        .mem_req_o       (mem_req),
        .mem_addr_o      (mem_addr),
        .mem_rsp_i       (mem_rsp),
        .mem_rsp_ready_o (mem_rsp_ready),
        .dec_o           (dec)
    );

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x         = rng_state;
        x         = x ^ (x << 13);
        x         = x ^ (x >> 17);
        x         = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic load_table();
        rows[0] = '{32'h0000_0000, 8'd0,   16'd24};   // 32-bit only region
        rows[1] = '{32'h0000_0100, 8'd0,   16'd40};   // Mixed sizes
        rows[2] = '{32'h0000_0202, 8'd0,   16'd12};   // Odd target with a compressed upper half
        rows[3] = '{32'h0000_0302, 8'd0,   16'd12};   // Odd target that starts a straddling one
        rows[4] = '{32'h0000_0140, 8'd0,   16'd3};
        rows[5] = '{32'h0000_0180, 8'd0,   16'd0};    // Flushed again while still draining
        rows[6] = '{32'h0000_01c0, 8'd90,  16'd40};
        rows[7] = '{32'h0000_03a2, 8'd170, 16'd30};   // Heavy stalls after an odd redirect
    endtask

    // Random mix of sizes where every halfword also mixes in its own byte address
    task automatic load_program();
        int          i;
        logic [31:0] r;
        i = 0;
        while (i < MEM_HALVES) begin
            r = next_rand() ^ (32'(i) << 1);
            if (i < 128 || r[4]) begin
                u_imem.prog[i] = {r[15:2], 2'b11};
                if (i + 1 < MEM_HALVES) begin
                    u_imem.prog[i + 1] = r[31:16];
                end
                i = i + 2;
            end else begin
                u_imem.prog[i] = {r[15:2], 1'b0, r[0]};   // Low bits never both set
                i = i + 1;
            end
        end
        u_imem.prog[32'h202 >> 1] = 16'h4a81;
        u_imem.prog[32'h302 >> 1] = 16'h8093;
    endtask

    function automatic fetch_pkg::half_t prog_half(input fetch_pkg::addr_t pc);
        return u_imem.prog[int'((pc >> 1) % MEM_HALVES)];
    endfunction

    // Instruction that starts at pc with compressed ones zero-extended
    function automatic fetch_pkg::word_t ref_inst(input fetch_pkg::addr_t pc);
        fetch_pkg::half_t lo;
        lo = prog_half(pc);
        if (lo[1:0] != 2'b11) begin
            return {16'h0000, lo};
        end
        return {prog_half(pc + 32'd2), lo};
    endfunction

    function automatic fetch_pkg::addr_t ref_size(input fetch_pkg::addr_t pc);
        fetch_pkg::half_t lo;
        lo = prog_half(pc);
        return (lo[1:0] != 2'b11) ? 32'd2 : 32'd4;
    endfunction

    function automatic int cycle_limit();
        int total;
        total = 100;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total = total + 12 * int'(rows[r].inst_count) + 40;
        end
        return total;
    endfunction

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input fetch_pkg::word_t exp,
                              input fetch_pkg::word_t got);
        if (got !== exp) begin
            $display("Error: %0t %s expected %08h got %08h", $time, name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t exp,
                              input fetch_pkg::addr_t got);
        if (got !== exp) begin
            $display("Error: %0t %s expected %08h got %08h", $time, name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: %0t %s expected %b got %b", $time, name, exp, got);
            stop_on_failure();
        end
    endtask

    initial begin
        int                  row;
        int                  done;
        int                  cyc;
        int                  limit;
        int                  in_flight;   // Reads the memory still owes an answer
        int                  stale;       // Of those, the ones issued before the last flush
        logic                acc;
        logic                hold_chk;
        logic [31:0]         r;
        fetch_pkg::addr_t    exp_pc;
        fetch_pkg::addr_t    exp_fetch;
        fetch_pkg::dec_out_t held;

        flush       = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        rng_state   = SEED;
        load_table();
        load_program();
        limit     = cycle_limit();
        row       = 0;
        done      = 0;
        cyc       = 0;
        in_flight = 0;
        stale     = 0;
        hold_chk  = 1'b0;
        exp_pc    = '0;   // Fetch starts at zero out of reset
        exp_fetch = '0;
        held      = '0;

        @(posedge rstn);
        flush       = 1'b1;
        redirect_pc = rows[0].redirect_pc;

        while (row < NUM_ROWS) begin
            @(posedge clk);
            cyc = cyc + 1;
            if (cyc > limit) begin
                $display("Timeout: scenario %0d still running after %0d cycles", row, cyc);
                stop_on_failure();
            end
            acc = mem_rsp.valid && mem_rsp_ready;
            check_bit("mem_req_o", !flush && ((in_flight - stale) < 2), mem_req);
            if (mem_req) begin
                check_addr("mem_addr_o", exp_fetch, mem_addr);
                exp_fetch = exp_fetch + 32'd4;
            end
            if (flush ? (in_flight != 0) : (stale != 0)) begin   // Old reads are thrown away
                check_bit("mem_rsp_ready_o", 1'b1, mem_rsp_ready);
            end else if (stall) begin
                check_bit("mem_rsp_ready_o", 1'b0, mem_rsp_ready);
            end
            if (flush) begin
                stale = in_flight - int'(acc);
            end else if (acc && stale != 0) begin
                stale = stale - 1;
            end
            in_flight = in_flight + int'(mem_req) - int'(acc);
            if (hold_chk) begin   // Decode stalled last cycle so nothing may move
                check_bit("dec_o.valid", held.valid, dec.valid);
                check_word("dec_o.inst", held.inst, dec.inst);
                check_addr("dec_o.pc", held.pc, dec.pc);
            end
            hold_chk = stall && dec.valid;
            held     = dec;
            if (dec.valid && !stall) begin
                check_word("dec_o.inst", ref_inst(exp_pc), dec.inst);
                check_addr("dec_o.pc", exp_pc, dec.pc);
                exp_pc = exp_pc + ref_size(exp_pc);
                done   = done + 1;
            end
            if (flush) begin
                exp_pc    = redirect_pc;
                exp_fetch = {redirect_pc[31:2], 2'b00};
                done      = 0;
            end

            #2;
            flush = 1'b0;
            r     = next_rand();
            stall = r[7:0] < rows[row].stall_level;
            if (done >= int'(rows[row].inst_count)) begin
                row = row + 1;
                if (row < NUM_ROWS) begin
                    flush       = 1'b1;
                    redirect_pc = rows[row].redirect_pc;
                    stall       = 1'b0;   // A stalled decode would hold the redirect off
                end
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_imem_model.sv
`default_nettype none
`timescale 1ns/1ps

module tb_imem_model #(
    parameter int HALVES = 1024
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_i,
    input  fetch_pkg::addr_t    addr_i,
    input  logic                rsp_ready_i,
    output fetch_pkg::mem_rsp_t rsp_o
);

    fetch_pkg::half_t prog [HALVES];   // Program image, one entry per halfword
    fetch_pkg::addr_t pend_addr [$];   // Reads waiting for an answer, oldest first
    int               pend_due [$];

    initial begin
        int               cyc;
        int               idx;
        logic             req_s;
        logic             ready_s;
        fetch_pkg::addr_t addr_s;

        cyc   = 0;
        rsp_o = '0;
        forever begin
            @(posedge clk_i);
            req_s   = req_i;
            addr_s  = addr_i;
            ready_s = rsp_ready_i && rsp_o.valid;
            cyc     = cyc + 1;
            if (!rstn_i) begin
                pend_addr.delete();
                pend_due.delete();
            end else begin
                if (ready_s) begin
                    pend_addr.delete(0);
                    pend_due.delete(0);
                end
                if (req_s) begin
                    pend_addr.push_back(addr_s);
                    pend_due.push_back(cyc + 1);   // Visible two cycles after the request
                end
            end
            #2;
            if (pend_addr.size() != 0 && pend_due[0] <= cyc) begin
                idx   = int'((pend_addr[0] >> 1) % HALVES);
                rsp_o = '{data: {prog[idx + 1], prog[idx]}, valid: 1'b1};
            end else begin
                rsp_o = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_inst_assemble.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_inst_assemble (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    stall_i,
    input  fetch_pkg::realign_ctl_t ctl_i,
    input  fetch_pkg::word_t        rsp_data_i,
    input  fetch_pkg::addr_t        head_pc_i,
    output logic [1:0]              buf_lo_bits_o,
    output fetch_pkg::dec_out_t     dec_o
);

    fetch_pkg::half_t rsp_lo;
    fetch_pkg::half_t rsp_hi;
    fetch_pkg::half_t buf_half_r;   // Upper half of an earlier word
    fetch_pkg::addr_t buf_pc_r;
    fetch_pkg::word_t inst_n;
    fetch_pkg::word_t inst_r;
    fetch_pkg::addr_t pc_n;
    fetch_pkg::addr_t pc_r;
    logic             valid_r;
    logic             from_buf;

    assign rsp_lo        = rsp_data_i[fetch_pkg::HALF_W-1:0];
    assign rsp_hi        = rsp_data_i[fetch_pkg::XLEN-1:fetch_pkg::HALF_W];
    assign buf_lo_bits_o = buf_half_r[1:0];   // Control decides if this half is compressed
    assign from_buf      = (ctl_i.out_sel == fetch_pkg::SEL_BUF_LO) ||
                           (ctl_i.out_sel == fetch_pkg::SEL_BUF_JOIN);

    always_comb begin
        case (ctl_i.out_sel)
            fetch_pkg::SEL_RESP_LO:  inst_n = {{fetch_pkg::HALF_W{1'b0}}, rsp_lo};
            fetch_pkg::SEL_RESP_HI:  inst_n = {{fetch_pkg::HALF_W{1'b0}}, rsp_hi};
            fetch_pkg::SEL_BUF_LO:   inst_n = {{fetch_pkg::HALF_W{1'b0}}, buf_half_r};
            fetch_pkg::SEL_BUF_JOIN: inst_n = {rsp_lo, buf_half_r};  // Straddles two words
            default:                 inst_n = rsp_data_i;
        endcase

        if (from_buf) begin
            pc_n = buf_pc_r;
        end else if (ctl_i.out_pc_hi) begin
            pc_n = head_pc_i + fetch_pkg::addr_t'(2);
        end else begin
            pc_n = head_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctl_i.buf_load) begin
            buf_half_r <= rsp_hi;
            buf_pc_r   <= head_pc_i + fetch_pkg::addr_t'(2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctl_i.out_load && !stall_i) begin
            inst_r <= inst_n;
            pc_r   <= pc_n;
        end
    end

    // Decode sees each instruction for one cycle unless it stalls
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_r <= 1'b0;
        end else if (!stall_i) begin
            if (ctl_i.out_clear) begin
                valid_r <= 1'b0;
            end else if (ctl_i.out_load) begin
                valid_r <= 1'b1;
            end
        end
    end

    assign dec_o = '{inst: inst_r, pc: pc_r, valid: valid_r};

endmodule

`default_nettype wire

// File: source/fetch_pc_gen.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,
    input  fetch_pkg::addr_t  redirect_pc_i,
    input  fetch_pkg::count_t queue_count_i,
    output logic              mem_req_o,
    output fetch_pkg::addr_t  mem_addr_o
);

    fetch_pkg::addr_t next_pc_r;   // Word address of the next read
    logic             run_r;       // High from the first cycle after reset
    logic             room;

    assign room       = queue_count_i < fetch_pkg::count_t'(fetch_pkg::MAX_OUTSTANDING);
    assign mem_req_o  = run_r && room && !flush_i;
    assign mem_addr_o = next_pc_r;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            run_r <= 1'b0;
        end else begin
            run_r <= 1'b1;
        end
    end

    // A redirect restarts on the word holding the target PC
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            next_pc_r <= '0;
        end else if (flush_i) begin
            next_pc_r <= redirect_pc_i & ~fetch_pkg::addr_t'(3);
        end else if (mem_req_o) begin
            next_pc_r <= next_pc_r + fetch_pkg::addr_t'(4);
        end
    end

    // Every strobe finds a free queue slot and is held there on the next cycle
    a_req_queued: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o |-> (queue_count_i < fetch_pkg::count_t'(fetch_pkg::MAX_OUTSTANDING))
                      ##1 (queue_count_i != '0));

endmodule

`default_nettype wire

// File: source/fetch_pc_queue.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_pc_queue (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              push_i,
    input  fetch_pkg::addr_t  push_pc_i,
    input  logic              pop_i,
    input  logic              clear_i,
    output fetch_pkg::addr_t  head_pc_o,
    output logic              head_valid_o,
    output fetch_pkg::count_t count_o
);

    fetch_pkg::addr_t  pc_mem [fetch_pkg::MAX_OUTSTANDING];
    logic              wr_ptr_r;   // One bit covers both entries and wraps by itself
    logic              rd_ptr_r;
    fetch_pkg::count_t count_r;

    assign head_pc_o    = pc_mem[rd_ptr_r];
    assign head_valid_o = count_r != '0;
    assign count_o      = count_r;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            pc_mem[wr_ptr_r] <= push_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
            count_r  <= '0;
        end else if (clear_i) begin
            // Outstanding PCs belong to the old path
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
            count_r  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_r <= count_r + fetch_pkg::count_t'(1);
                2'b01:   count_r <= count_r - fetch_pkg::count_t'(1);
                default: count_r <= count_r;  // Push and pop together keep the level
            endcase
        end
    end

    // Fetch two only takes a word whose PC is here, fetch one only reads into a free slot
    a_no_over_under: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(pop_i && count_r == '0) &&
        !(push_i && count_r == fetch_pkg::count_t'(fetch_pkg::MAX_OUTSTANDING)));

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int XLEN            = 32;
    localparam int HALF_W          = 16;
    localparam int MAX_OUTSTANDING = 2;   // Reads in flight between fetch one and fetch two

    typedef logic [XLEN-1:0]   addr_t;    // Byte address of a fetch or an instruction
    typedef logic [XLEN-1:0]   word_t;    // Memory word or a whole instruction
    typedef logic [HALF_W-1:0] half_t;
    typedef logic [1:0]        count_t;   // Outstanding reads, 0 to MAX_OUTSTANDING

    // Where the next decode instruction comes from
    typedef enum logic [2:0] {
        SEL_WORD     = 3'd0,  // Whole response word
        SEL_RESP_LO  = 3'd1,  // Low response half, zero-extended
        SEL_RESP_HI  = 3'd2,  // High response half, zero-extended
        SEL_BUF_LO   = 3'd3,  // Buffered half, zero-extended
        SEL_BUF_JOIN = 3'd4   // Buffered half below the low response half
    } asm_sel_e;

    // Per-cycle orders from the realign FSM to the datapath
    typedef struct packed {
        logic     out_load;   // Capture a new instruction for decode
        asm_sel_e out_sel;
        logic     out_pc_hi;  // Output PC is word PC plus 2
        logic     buf_load;   // Keep the high response half for later
        logic     out_clear;  // Nothing new for decode this cycle
    } realign_ctl_t;

    typedef enum logic [1:0] {
        ST_EMPTY = 2'd0,
        ST_HALF  = 2'd1,      // Upper half of a word is waiting in the buffer
        ST_DRAIN = 2'd2       // Throwing away responses to reads before a flush
    } fetch_state_e;

    typedef struct packed {
        word_t data;
        logic  valid;
    } mem_rsp_t;

    typedef struct packed {
        word_t inst;
        addr_t pc;
        logic  valid;
    } dec_out_t;

endpackage

`default_nettype wire

// File: source/fetch_realign_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_realign_ctrl (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    flush_i,
    input  fetch_pkg::addr_t        redirect_pc_i,
    input  logic                    stall_i,
    input  logic                    rsp_valid_i,
    input  logic [1:0]              rsp_lo_bits_i,
    input  logic [1:0]              rsp_hi_bits_i,
    input  logic                    head_valid_i,
    input  fetch_pkg::addr_t        head_pc_i,
    input  fetch_pkg::count_t       queue_count_i,
    input  logic [1:0]              buf_lo_bits_i,
    output logic                    rsp_ready_o,
    output logic                    pop_o,
    output fetch_pkg::realign_ctl_t ctl_o
);

    fetch_pkg::fetch_state_e state_r;
    fetch_pkg::fetch_state_e state_n;
    fetch_pkg::count_t       stale_r;      // Responses still owed to the old path
    fetch_pkg::count_t       stale_n;
    logic                    first_r;      // No instruction sent since reset or redirect
    logic                    first_n;
    logic                    odd_r;        // Redirect target sat in the upper half of its word
    logic                    odd_n;

    logic       lo_c;
    logic       hi_c;
    logic       buf_c;
    logic       skip_lo;
    logic       take;
    logic [2:0] stale_sum;   // One bit wider, a flush can land in the middle of a drain
    logic [2:0] stale_left;

    // A half is a compressed instruction unless both low bits are set
    assign lo_c    = rsp_lo_bits_i != 2'b11;
    assign hi_c    = rsp_hi_bits_i != 2'b11;
    assign buf_c   = buf_lo_bits_i != 2'b11;
    assign skip_lo = first_r && odd_r;
    assign take    = rsp_valid_i && head_valid_i && !stall_i;

    // Everything in the queue is stale on a flush, plus what a running drain still waits for
    assign stale_sum  = {1'b0, queue_count_i} +
                        ((state_r == fetch_pkg::ST_DRAIN) ? {1'b0, stale_r} : 3'd0);
    assign stale_left = stale_sum - {2'b00, rsp_valid_i && (stale_sum != 3'd0)};

    always_comb begin
        state_n     = state_r;
        stale_n     = stale_r;
        first_n     = first_r;
        odd_n       = odd_r;
        rsp_ready_o = 1'b0;
        ctl_o       = '0;

        case (state_r)
            fetch_pkg::ST_EMPTY: begin
                rsp_ready_o = take;
                if (take) begin
                    if (!skip_lo && !lo_c) begin
                        ctl_o.out_load = 1'b1;
                        ctl_o.out_sel  = fetch_pkg::SEL_WORD;
                    end else if (!skip_lo) begin
                        ctl_o.out_load = 1'b1;
                        ctl_o.out_sel  = fetch_pkg::SEL_RESP_LO;
                        ctl_o.buf_load = 1'b1;
                        state_n        = fetch_pkg::ST_HALF;
                    end else if (!hi_c) begin
                        ctl_o.buf_load = 1'b1;   // First half of a straddling instruction
                        state_n        = fetch_pkg::ST_HALF;
                    end else begin
                        ctl_o.out_load  = 1'b1;
                        ctl_o.out_sel   = fetch_pkg::SEL_RESP_HI;
                        ctl_o.out_pc_hi = 1'b1;
                    end
                end
            end
            fetch_pkg::ST_HALF: begin
                if (!stall_i && buf_c) begin
                    // The waiting half is complete by itself so the response is left alone
                    ctl_o.out_load = 1'b1;
                    ctl_o.out_sel  = fetch_pkg::SEL_BUF_LO;
                    state_n        = fetch_pkg::ST_EMPTY;
                end else begin
                    rsp_ready_o = take;
                    if (take) begin
                        ctl_o.out_load = 1'b1;
                        ctl_o.out_sel  = fetch_pkg::SEL_BUF_JOIN;
                        ctl_o.buf_load = 1'b1;
                    end
                end
            end
            fetch_pkg::ST_DRAIN: begin
                rsp_ready_o = 1'b1;
                if (rsp_valid_i) begin
                    stale_n = stale_r - fetch_pkg::count_t'(1);
                    if (stale_r == fetch_pkg::count_t'(1)) begin
                        state_n = fetch_pkg::ST_EMPTY;
                    end
                end
            end
            default: begin
                state_n = fetch_pkg::ST_EMPTY;
            end
        endcase

        pop_o   = rsp_ready_o && rsp_valid_i && (state_r != fetch_pkg::ST_DRAIN);
        first_n = first_r && !ctl_o.out_load;

        if (flush_i) begin
            ctl_o.out_load = 1'b0;
            ctl_o.buf_load = 1'b0;
            pop_o          = 1'b0;
            rsp_ready_o    = stale_sum != 3'd0;
            first_n        = 1'b1;
            odd_n          = redirect_pc_i[1];
            stale_n        = stale_left[1:0];
            state_n        = (stale_left != 3'd0) ? fetch_pkg::ST_DRAIN : fetch_pkg::ST_EMPTY;
        end

        ctl_o.out_clear = !ctl_o.out_load;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_r <= fetch_pkg::ST_EMPTY;
            stale_r <= '0;
            first_r <= 1'b1;
            odd_r   <= 1'b0;
        end else begin
            state_r <= state_n;
            stale_r <= stale_n;
            first_r <= first_n;
            odd_r   <= odd_n;
        end
    end

    // Fetch one must not run so far ahead that the drain counter overflows
    a_drain_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |-> stale_left <= 3'(fetch_pkg::MAX_OUTSTANDING));

    a_stall_blocks_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (stall_i && state_r != fetch_pkg::ST_DRAIN) |-> !rsp_ready_o);

    // The queue only ever holds word addresses, halfword offsets come from odd_r
    a_head_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        pop_o |-> head_pc_i[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    input  fetch_pkg::addr_t    redirect_pc_i,
    input  logic                stall_i,
    output logic                mem_req_o,
    output fetch_pkg::addr_t    mem_addr_o,
    input  fetch_pkg::mem_rsp_t mem_rsp_i,
    output logic                mem_rsp_ready_o,
    output fetch_pkg::dec_out_t dec_o
);

    logic                    flush_take;   // Redirect that actually happens this cycle
    logic                    pop;
    fetch_pkg::addr_t        head_pc;
    logic                    head_valid;
    fetch_pkg::count_t       queue_count;
    fetch_pkg::realign_ctl_t ctl;
    logic [1:0]              buf_lo_bits;

    // A stalled decode holds the redirect off until it lets go
    assign flush_take = flush_i && !stall_i;

    fetch_pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_take),
        .redirect_pc_i (redirect_pc_i),
        .queue_count_i (queue_count),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o)
    );

    fetch_pc_queue u_pc_queue (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .push_i       (mem_req_o),
        .push_pc_i    (mem_addr_o),
        .pop_i        (pop),
        .clear_i      (flush_take),
        .head_pc_o    (head_pc),
        .head_valid_o (head_valid),
        .count_o      (queue_count)
    );

    fetch_realign_ctrl u_realign_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_take),
        .redirect_pc_i (redirect_pc_i),
        .stall_i       (stall_i),
        .rsp_valid_i   (mem_rsp_i.valid),
        .rsp_lo_bits_i (mem_rsp_i.data[1:0]),
        .rsp_hi_bits_i (mem_rsp_i.data[fetch_pkg::HALF_W+1:fetch_pkg::HALF_W]),
        .head_valid_i  (head_valid),
        .head_pc_i     (head_pc),
        .queue_count_i (queue_count),
        .buf_lo_bits_i (buf_lo_bits),
        .rsp_ready_o   (mem_rsp_ready_o),
        .pop_o         (pop),
        .ctl_o         (ctl)
    );

    fetch_inst_assemble u_inst_assemble (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .stall_i       (stall_i),
        .ctl_i         (ctl),
        .rsp_data_i    (mem_rsp_i.data),
        .head_pc_i     (head_pc),
        .buf_lo_bits_o (buf_lo_bits),
        .dec_o         (dec_o)
    );

endmodule

`default_nettype wire

// File: vlog.f
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/fetch_pc_queue.sv
source/fetch_realign_ctrl.sv
source/fetch_inst_assemble.sv
source/fetch_top.sv
dv/tb_clock_gen.sv
dv/tb_imem_model.sv
dv/tb_fetch_top.sv
